// ==== Makefile ====
TOP     := tb_dac_engine
SIM_LOG := sim.log

.PHONY: all compile run clean

all: run

# build the simulator from the file list
compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f dac_engine.f

# run, then look for the pass line in the log
run: compile
	./obj_dir/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@grep -q "^Simulation passed$$" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== dac_engine.f ====
hw/dac_engine_pkg.sv
hw/dac_engine_regs.sv
hw/lut_player.sv
hw/pulse_gen.sv
hw/dac_output_mux.sv
hw/dac_engine.sv
test/dac_engine_properties.sv
test/tb_dac_engine.sv

// ==== hw/dac_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module dac_engine (
    input  wire                                    adc_clk,
    input  wire                                    reset,
    // axi4-lite slave
    input  wire  [dac_engine_pkg::REG_ADDR_W-1:0]  awaddr,
    input  wire                                    awvalid,
    output logic                                   awready,
    input  wire  [31:0]                            wdata,
    input  wire                                    wvalid,
    output logic                                   wready,
    output logic                                   bvalid,
    output logic [1:0]                             bresp,
    input  wire                                    bready,
    input  wire  [dac_engine_pkg::REG_ADDR_W-1:0]  araddr,
    input  wire                                    arvalid,
    output logic                                   arready,
    output logic [31:0]                            rdata,
    output logic                                   rvalid,
    output logic [1:0]                             rresp,
    input  wire                                    rready,
    // dac words, offset binary
    output logic [dac_engine_pkg::DATA_W-1:0]      dac_a,
    output logic [dac_engine_pkg::DATA_W-1:0]      dac_b
);
    import dac_engine_pkg::*;

    // register block outputs
    logic [SEL_W-1:0]      dac_a_select;
    logic [SEL_W-1:0]      dac_b_select;
    logic                  lut_run_once;
    logic                  trig_pulse;   // to both sources
    logic                  lut_wr_en;
    logic [LUT_ADDR_W-1:0] lut_wr_addr;
    logic [DATA_W-1:0]     lut_wr_data;
    logic [PERIOD_W-1:0]   pulse_low;
    logic [PERIOD_W-1:0]   pulse_high;
    logic [DATA_W-1:0]     pulse_val;

    // source words into the output mux
    logic [DATA_W-1:0]     lut_sample;
    logic [DATA_W-1:0]     pulse_sample;

    // port and wire names match throughout
    dac_engine_regs i_regs (
        .*
    );

    lut_player i_lut_player (
        .*
    );

    pulse_gen i_pulse_gen (
        .*
    );

    dac_output_mux i_dac_output_mux (
        .*
    );

endmodule

`default_nettype wire

// ==== hw/dac_engine_pkg.sv ====
`default_nettype none

package dac_engine_pkg;

    // datapath widths
    localparam int DATA_W     = 16;  // dac and lut sample
    localparam int LUT_ADDR_W = 8;   // 256 pattern entries
    localparam int PERIOD_W   = 32;  // pulse phase lengths
    localparam int REG_ADDR_W = 5;   // axi byte address
    localparam int SEL_W      = 2;

    // register map, byte offsets
    localparam logic [REG_ADDR_W-1:0] REG_ID         = 5'h00;  // read only
    localparam logic [REG_ADDR_W-1:0] REG_CTRL       = 5'h04;  // selects, run once
    localparam logic [REG_ADDR_W-1:0] REG_TRIG       = 5'h08;  // bit 0 fires trigger
    localparam logic [REG_ADDR_W-1:0] REG_LUT        = 5'h0C;  // {addr, sample}
    localparam logic [REG_ADDR_W-1:0] REG_PULSE_LOW  = 5'h10;
    localparam logic [REG_ADDR_W-1:0] REG_PULSE_HIGH = 5'h14;
    localparam logic [REG_ADDR_W-1:0] REG_PULSE_VAL  = 5'h18;

    // dac a source codes
    localparam logic [SEL_W-1:0] SEL_A_PULSE = 2'd0;
    localparam logic [SEL_W-1:0] SEL_A_LUT   = 2'd1;
    localparam logic [SEL_W-1:0] SEL_A_HIGH  = 2'd2;
    localparam logic [SEL_W-1:0] SEL_A_LOW   = 2'd3;

    // dac b uses a different order, matches the board software
    localparam logic [SEL_W-1:0] SEL_B_LUT   = 2'd0;
    localparam logic [SEL_W-1:0] SEL_B_PULSE = 2'd1;
    localparam logic [SEL_W-1:0] SEL_B_LOW   = 2'd2;
    localparam logic [SEL_W-1:0] SEL_B_HIGH  = 2'd3;

    // fixed levels, two's complement
    localparam logic [DATA_W-1:0] LEVEL_HIGH = 16'h4000;  // +half scale
    localparam logic [DATA_W-1:0] LEVEL_LOW  = 16'hC000;  // -half scale

    // id word is {rev, type}
    localparam logic [15:0] FPGA_TYPE = 16'hABCD;
    localparam logic [15:0] FPGA_REV  = 16'h1237;

endpackage

`default_nettype wire

// ==== hw/dac_engine_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module dac_engine_regs (
    input  wire                                    adc_clk,
    input  wire                                    reset,
    // axi4-lite write side
    input  wire  [dac_engine_pkg::REG_ADDR_W-1:0]  awaddr,
    input  wire                                    awvalid,
    output logic                                   awready,
    input  wire  [31:0]                            wdata,
    input  wire                                    wvalid,
    output logic                                   wready,
    output logic                                   bvalid,
    output logic [1:0]                             bresp,
    input  wire                                    bready,
    // axi4-lite read side
    input  wire  [dac_engine_pkg::REG_ADDR_W-1:0]  araddr,
    input  wire                                    arvalid,
    output logic                                   arready,
    output logic [31:0]                            rdata,
    output logic                                   rvalid,
    output logic [1:0]                             rresp,
    input  wire                                    rready,
    // register outputs
    output logic [dac_engine_pkg::SEL_W-1:0]       dac_a_select,
    output logic [dac_engine_pkg::SEL_W-1:0]       dac_b_select,
    output logic                                   lut_run_once,
    output logic                                   trig_pulse,
    output logic                                   lut_wr_en,
    output logic [dac_engine_pkg::LUT_ADDR_W-1:0]  lut_wr_addr,
    output logic [dac_engine_pkg::DATA_W-1:0]      lut_wr_data,
    output logic [dac_engine_pkg::PERIOD_W-1:0]    pulse_low,
    output logic [dac_engine_pkg::PERIOD_W-1:0]    pulse_high,
    output logic [dac_engine_pkg::DATA_W-1:0]      pulse_val
);
    import dac_engine_pkg::*;

    logic        wr_accept;  // aw and w taken on this edge
    logic        rd_accept;  // ar taken on this edge
    logic [31:0] lut_reg;    // last word written to REG_LUT
    logic [31:0] rd_word;    // read decode

    assign wr_accept = awready && awvalid && wvalid;
    assign rd_accept = arready && arvalid;

    assign bresp = 2'b00;  // always OKAY
    assign rresp = 2'b00;

    // entry address in the upper halfword, sample in the lower
    assign lut_wr_addr = lut_reg[16 +: LUT_ADDR_W];
    assign lut_wr_data = lut_reg[DATA_W-1:0];

    // write channel
    // aw and w accepted together, only while no response is outstanding
    always_ff @(posedge adc_clk or posedge reset) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;  // one cycle pulse
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;  // held under back-pressure
            end
        end
    end

    // register file
    always_ff @(posedge adc_clk or posedge reset) begin
        if (reset) begin
            dac_a_select <= '0;
            dac_b_select <= '0;
            lut_run_once <= 1'b0;
            trig_pulse   <= 1'b0;
            lut_wr_en    <= 1'b0;
            lut_reg      <= '0;
            pulse_low    <= '0;
            pulse_high   <= '0;
            pulse_val    <= '0;
        end else begin
            trig_pulse <= 1'b0;  // strobes last a single cycle
            lut_wr_en  <= 1'b0;
            if (wr_accept) begin
                case (awaddr)
                    REG_CTRL: begin
                        dac_a_select <= wdata[0 +: SEL_W];
                        dac_b_select <= wdata[4 +: SEL_W];
                        lut_run_once <= wdata[8];
                    end
                    REG_TRIG: trig_pulse <= wdata[0];  // writing 0 does nothing
                    REG_LUT: begin
                        lut_reg   <= wdata;
                        lut_wr_en <= 1'b1;  // ram sees it next edge
                    end
                    REG_PULSE_LOW:  pulse_low  <= wdata;
                    REG_PULSE_HIGH: pulse_high <= wdata;
                    REG_PULSE_VAL:  pulse_val  <= wdata[DATA_W-1:0];
                    default: ;  // id and unmapped offsets ignore writes
                endcase
            end
        end
    end

    // read decode
    always_comb begin
        case (araddr)
            REG_ID:         rd_word = {FPGA_REV, FPGA_TYPE};
            REG_CTRL:       rd_word = {23'b0, lut_run_once, 2'b0, dac_b_select,
                                       2'b0, dac_a_select};
            REG_LUT:        rd_word = lut_reg;
            REG_PULSE_LOW:  rd_word = pulse_low;
            REG_PULSE_HIGH: rd_word = pulse_high;
            REG_PULSE_VAL:  rd_word = {16'b0, pulse_val};
            default:        rd_word = 32'b0;  // trig reads 0 as well
        endcase
    end

    // read channel
    always_ff @(posedge adc_clk or posedge reset) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read data, captured once and held until rready
    always_ff @(posedge adc_clk) begin
        if (rd_accept) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dac_output_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module dac_output_mux (
    input  wire                                adc_clk,
    input  wire                                reset,
    input  wire  [dac_engine_pkg::SEL_W-1:0]   dac_a_select,
    input  wire  [dac_engine_pkg::SEL_W-1:0]   dac_b_select,
    input  wire  [dac_engine_pkg::DATA_W-1:0]  lut_sample,
    input  wire  [dac_engine_pkg::DATA_W-1:0]  pulse_sample,
    output logic [dac_engine_pkg::DATA_W-1:0]  dac_a,  // offset binary
    output logic [dac_engine_pkg::DATA_W-1:0]  dac_b
);
    import dac_engine_pkg::*;

    logic [DATA_W-1:0] a_signed;  // selected word, two's complement
    logic [DATA_W-1:0] b_signed;

    // first stage, per channel source select
    always_ff @(posedge adc_clk or posedge reset) begin
        if (reset) begin
            a_signed <= '0;
            b_signed <= '0;
        end else begin
            case (dac_a_select)
                SEL_A_PULSE: a_signed <= pulse_sample;
                SEL_A_LUT:   a_signed <= lut_sample;
                SEL_A_HIGH:  a_signed <= LEVEL_HIGH;
                default:     a_signed <= LEVEL_LOW;   // SEL_A_LOW
            endcase
            case (dac_b_select)
                SEL_B_LUT:   b_signed <= lut_sample;
                SEL_B_PULSE: b_signed <= pulse_sample;
                SEL_B_LOW:   b_signed <= LEVEL_LOW;
                default:     b_signed <= LEVEL_HIGH;  // SEL_B_HIGH
            endcase
        end
    end

    // second stage, flip msb for the dac
    // reset value is midscale, same as a signed 0
    always_ff @(posedge adc_clk or posedge reset) begin
        if (reset) begin
            dac_a <= {1'b1, {(DATA_W-1){1'b0}}};
            dac_b <= {1'b1, {(DATA_W-1){1'b0}}};
        end else begin
            dac_a <= {~a_signed[DATA_W-1], a_signed[DATA_W-2:0]};
            dac_b <= {~b_signed[DATA_W-1], b_signed[DATA_W-2:0]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/lut_player.sv ====
`timescale 1ns/100ps
`default_nettype none

module lut_player (
    input  wire                                    adc_clk,
    input  wire                                    reset,
    input  wire                                    lut_run_once,
    input  wire                                    trig_pulse,
    input  wire                                    lut_wr_en,
    input  wire  [dac_engine_pkg::LUT_ADDR_W-1:0]  lut_wr_addr,
    input  wire  [dac_engine_pkg::DATA_W-1:0]      lut_wr_data,
    output logic [dac_engine_pkg::DATA_W-1:0]      lut_sample
);
    import dac_engine_pkg::*;

    logic [DATA_W-1:0]     pattern_ram [2**LUT_ADDR_W];
    logic [LUT_ADDR_W-1:0] rd_addr;    // sequencer address
    logic                  addr_last;  // carry out of the counter
    logic                  addr_en;

    assign addr_last = &rd_addr;

    // free run unless run once is set
    // in run once the counter parks on 255 until a trigger restarts it
    assign addr_en = !addr_last || !lut_run_once || trig_pulse;

    always_ff @(posedge adc_clk or posedge reset) begin
        if (reset) begin
            rd_addr <= '0;
        end else if (addr_en) begin
            rd_addr <= rd_addr + LUT_ADDR_W'(1);  // 255 wraps to 0
        end
    end

    // software write port
    always_ff @(posedge adc_clk) begin
        if (lut_wr_en) begin
            pattern_ram[lut_wr_addr] <= lut_wr_data;
        end
    end

    // registered read, sample lags address by one
    always_ff @(posedge adc_clk) begin
        lut_sample <= pattern_ram[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/pulse_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module pulse_gen (
    input  wire                                  adc_clk,
    input  wire                                  reset,
    input  wire                                  trig_pulse,
    input  wire  [dac_engine_pkg::PERIOD_W-1:0]  pulse_low,   // cycles at 0
    input  wire  [dac_engine_pkg::PERIOD_W-1:0]  pulse_high,  // cycles at pulse_val
    input  wire  [dac_engine_pkg::DATA_W-1:0]    pulse_val,
    output logic [dac_engine_pkg::DATA_W-1:0]    pulse_sample
);
    import dac_engine_pkg::*;

    logic                in_low;     // low phase running
    logic                in_high;    // high phase running
    logic [PERIOD_W-1:0] phase_cnt;  // cycles left in this phase

    // idle when neither phase flag is set
    always_ff @(posedge adc_clk or posedge reset) begin
        if (reset) begin
            in_low    <= 1'b0;
            in_high   <= 1'b0;
            phase_cnt <= '0;
        end else if (trig_pulse) begin
            // restart, also mid pulse
            // a zero length phase is skipped
            in_low    <= (pulse_low != '0);
            in_high   <= (pulse_low == '0) && (pulse_high != '0);
            phase_cnt <= (pulse_low != '0) ? pulse_low : pulse_high;
        end else if (in_low) begin
            if (phase_cnt == PERIOD_W'(1)) begin
                in_low    <= 1'b0;
                in_high   <= (pulse_high != '0);
                phase_cnt <= pulse_high;  // load high length
            end else begin
                phase_cnt <= phase_cnt - PERIOD_W'(1);
            end
        end else if (in_high) begin
            if (phase_cnt == PERIOD_W'(1)) begin
                in_high   <= 1'b0;  // back to idle
                phase_cnt <= '0;
            end else begin
                phase_cnt <= phase_cnt - PERIOD_W'(1);
            end
        end
    end

    // step only during the high phase
    assign pulse_sample = in_high ? pulse_val : '0;

endmodule

`default_nettype wire

// ==== test/dac_engine_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module dac_engine_properties (
    input wire        adc_clk,
    input wire        reset,
    input wire        awready,
    input wire        wready,
    input wire        bvalid,
    input wire        bready,
    input wire        arready,
    input wire        rvalid,
    input wire        rready,
    input wire [31:0] rdata
);

    // write response waits for the master
    property bvalid_held;
        @(posedge adc_clk) disable iff (reset)
            bvalid && !bready |=> bvalid;
    endproperty

    // read data frozen while stalled
    property read_data_held;
        @(posedge adc_clk) disable iff (reset)
            rvalid && !rready |=> rvalid && $stable(rdata);
    endproperty

    property quiet_in_reset;
        @(posedge adc_clk)
            reset |-> !awready && !wready && !bvalid && !arready && !rvalid;
    endproperty

    assert_bvalid_held: assert property (bvalid_held)
        else $error("bvalid dropped before bready");
    assert_read_data_held: assert property (read_data_held)
        else $error("rvalid or rdata changed before rready");
    assert_quiet_in_reset: assert property (quiet_in_reset)
        else $error("handshake output high during reset");

endmodule

bind dac_engine_regs dac_engine_properties i_properties (
    .adc_clk (adc_clk),
    .reset   (reset),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata)
);

`default_nettype wire

// ==== test/tb_dac_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dac_engine;
    import dac_engine_pkg::*;

    localparam int CLK_NS = 100;
    // cycle budget per test: readback, levels, free run, run once, pulse, stalls
    localparam int TEST_CYCLES   = 200 + 50 + 1500 + 600 + 100 + 1000;
    localparam int MARGIN_CYCLES = 1000;

    logic        adc_clk = 1'b0;
    logic        reset;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic [1:0]  rresp;
    logic        rready;
    logic [15:0] dac_a;
    logic [15:0] dac_b;

    int          error_count = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    logic [31:0] lut_seed    = 32'd78980;  // lut contents and test data
    logic [31:0] stall_seed  = 32'd78980;  // bready and rready pattern
    logic        stall_en    = 1'b0;
    logic [15:0] lut_mem [256];            // expected pattern ram

    always #(CLK_NS / 2) adc_clk = ~adc_clk;

    dac_engine i_dut (
        .adc_clk (adc_clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rresp   (rresp),
        .rready  (rready),
        .dac_a   (dac_a),
        .dac_b   (dac_b)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // two's complement to offset binary
    function automatic logic [15:0] to_offset(input logic [15:0] value);
        return value + 16'h8000;  // shift up by half scale
    endfunction

    function automatic bit already_loaded(input logic [15:0] value, input int count);
        int k;
        already_loaded = 1'b0;
        for (k = 0; k < count; k++) begin
            if (lut_mem[k] == value) already_loaded = 1'b1;
        end
    endfunction

    // response ready, random only while stalling
    initial begin
        bready = 1'b1;
        rready = 1'b1;
        forever begin
            @(posedge adc_clk);
            if (stall_en) begin
                stall_seed = lcg_next(stall_seed);
                bready <= stall_seed[16];
                rready <= stall_seed[20];
            end else begin
                bready <= 1'b1;
                rready <= 1'b1;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s expected 0x%h got 0x%h", name, expected, actual);
        error_count++;
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    // lag is the number of edges from the aw/w handshake to the b handshake
    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data, output int lag);
        int waited;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        waited = 0;
        do begin
            @(posedge adc_clk);
            waited++;
        end while (!awready && waited < 100);  // pre-edge value
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!awready) begin
            $display("write to 0x%h was never accepted", addr);
            error_count++;
        end else if (wready !== 1'b1) begin
            report_mismatch("wready", 32'h1, 32'(wready));  // raised with awready
        end
        lag = 0;
        do begin
            @(posedge adc_clk);
            lag++;
        end while (!(bvalid && bready) && lag < 100);
        if (!(bvalid && bready)) begin
            $display("write to 0x%h got no response", addr);
            error_count++;
        end else if (bresp !== 2'b00) begin
            report_mismatch("bresp", 32'h0, 32'(bresp));  // OKAY
        end
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
        int waited;
        araddr  <= addr;
        arvalid <= 1'b1;
        waited = 0;
        do begin
            @(posedge adc_clk);
            waited++;
        end while (!arready && waited < 100);
        arvalid <= 1'b0;
        waited = 0;
        do begin
            @(posedge adc_clk);
            waited++;
        end while (!(rvalid && rready) && waited < 100);
        data = rdata;  // held while rvalid
        if (!(rvalid && rready)) begin
            $display("read from 0x%h returned no data", addr);
            error_count++;
        end else if (rresp !== 2'b00) begin
            report_mismatch("rresp", 32'h0, 32'(rresp));  // OKAY
        end
    endtask

    task automatic read_expect(input logic [4:0] addr, input logic [31:0] expected,
                               input string name);
        logic [31:0] data;
        axi_read(addr, data);
        if (data !== expected) report_mismatch(name, expected, data);
    endtask

    task automatic register_readback();
        int start;
        int lag;
        start = error_count;
        if (dac_a !== 16'h8000) report_mismatch("dac_a(reset)", 32'h8000, 32'(dac_a));
        if (dac_b !== 16'h8000) report_mismatch("dac_b(reset)", 32'h8000, 32'(dac_b));
        read_expect(REG_ID, 32'h1237_ABCD, "rdata(id)");
        axi_write(REG_CTRL, 32'hFFFF_FFFF, lag);
        read_expect(REG_CTRL, 32'h0000_0133, "rdata(ctrl)");  // only mapped bits
        axi_write(REG_TRIG, 32'h1, lag);
        read_expect(REG_TRIG, 32'h0, "rdata(trig)");
        axi_write(REG_LUT, 32'h00AB_1234, lag);
        read_expect(REG_LUT, 32'h00AB_1234, "rdata(lut)");
        axi_write(REG_PULSE_LOW, 32'hDEAD_BEEF, lag);
        read_expect(REG_PULSE_LOW, 32'hDEAD_BEEF, "rdata(pulse_low)");
        axi_write(REG_PULSE_HIGH, 32'h0000_0010, lag);
        read_expect(REG_PULSE_HIGH, 32'h0000_0010, "rdata(pulse_high)");
        axi_write(REG_PULSE_VAL, 32'h5A5A_A5A5, lag);
        read_expect(REG_PULSE_VAL, 32'h0000_A5A5, "rdata(pulse_val)");
        axi_write(5'h1C, 32'hFFFF_FFFF, lag);
        read_expect(5'h1C, 32'h0, "rdata(unmapped)");
        axi_write(REG_CTRL, 32'h0, lag);
        close_test("register_readback", start);
    endtask

    task automatic fixed_levels();
        int start;
        int lag;
        start = error_count;
        axi_write(REG_CTRL, 32'h0000_0022, lag);  // a high, b low
        if (lag > 2) begin
            $display("write response came too late to check the level latency");
            error_count++;
        end else begin
            repeat (3 - lag) @(posedge adc_clk);
            if (dac_a !== to_offset(16'h4000)) report_mismatch("dac_a", 32'hC000, 32'(dac_a));
            if (dac_b !== to_offset(16'hC000)) report_mismatch("dac_b", 32'h4000, 32'(dac_b));
            axi_write(REG_CTRL, 32'h0000_0033, lag);  // a low, b high
            repeat (2 - lag) @(posedge adc_clk);
            // one edge early, old levels still out
            if (dac_a !== 16'hC000) report_mismatch("dac_a(early)", 32'hC000, 32'(dac_a));
            if (dac_b !== 16'h4000) report_mismatch("dac_b(early)", 32'h4000, 32'(dac_b));
            @(posedge adc_clk);
            if (dac_a !== to_offset(16'hC000)) report_mismatch("dac_a", 32'h4000, 32'(dac_a));
            if (dac_b !== to_offset(16'h4000)) report_mismatch("dac_b", 32'hC000, 32'(dac_b));
        end
        close_test("fixed_levels", start);
    endtask

    task automatic free_run_pattern();
        int          start;
        int          lag;
        int          i;
        int          idx;
        logic [15:0] value;
        start = error_count;
        for (i = 0; i < 256; i++) begin
            do begin
                lut_seed = lcg_next(lut_seed);
                value = lut_seed[31:16];
            end while (already_loaded(value, i));  // keeps entries distinct
            lut_mem[i] = value;
            axi_write(REG_LUT, {8'h00, 8'(i), value}, lag);
        end
        axi_write(REG_CTRL, 32'h0000_0001, lag);  // a from lut, free run
        repeat (4) @(posedge adc_clk);
        idx = -1;
        for (i = 0; i < 256; i++) begin
            if (to_offset(lut_mem[i]) == dac_a) idx = i;
        end
        if (idx < 0) begin
            $display("dac_a value 0x%h matches no loaded LUT entry", dac_a);
            error_count++;
        end else begin
            for (i = 0; i < 300; i++) begin  // more than one wrap
                @(posedge adc_clk);
                idx = (idx + 1) % 256;
                if (dac_a !== to_offset(lut_mem[idx])) begin
                    report_mismatch("dac_a", 32'(to_offset(lut_mem[idx])), 32'(dac_a));
                end
            end
        end
        close_test("free_run", start);
    endtask

    task automatic run_once_pattern();
        int          start;
        int          lag;
        int          i;
        int          waited;
        logic [15:0] parked;
        start = error_count;
        parked = to_offset(lut_mem[255]);
        axi_write(REG_CTRL, 32'h0000_0101, lag);
        repeat (264) @(posedge adc_clk);  // sequencer reaches its last address
        for (i = 0; i < 8; i++) begin
            if (dac_a !== parked) report_mismatch("dac_a(parked)", 32'(parked), 32'(dac_a));
            @(posedge adc_clk);
        end
        axi_write(REG_TRIG, 32'h1, lag);
        waited = 0;
        while (dac_a === parked && waited < 20) begin
            @(posedge adc_clk);
            waited++;
        end
        if (dac_a === parked) begin
            $display("trigger did not start a new LUT pass");
            error_count++;
        end else begin
            for (i = 0; i < 256; i++) begin  // one full pass in order
                if (dac_a !== to_offset(lut_mem[i])) begin
                    report_mismatch("dac_a(pass)", 32'(to_offset(lut_mem[i])), 32'(dac_a));
                end
                @(posedge adc_clk);
            end
            for (i = 0; i < 8; i++) begin
                if (dac_a !== parked) report_mismatch("dac_a(parked)", 32'(parked), 32'(dac_a));
                @(posedge adc_clk);
            end
        end
        close_test("run_once", start);
    endtask

    task automatic step_pulse();
        int          start;
        int          lag;
        int          i;
        int          high_cnt;
        int          after_cnt;
        logic [15:0] step;
        start = error_count;
        lut_seed = lcg_next(lut_seed);
        step = lut_seed[31:16] | 16'h0001;  // nonzero so the step is visible
        axi_write(REG_CTRL, 32'h0000_0010, lag);  // b from pulse
        axi_write(REG_PULSE_LOW, 32'd4, lag);
        axi_write(REG_PULSE_HIGH, 32'd7, lag);
        axi_write(REG_PULSE_VAL, {16'h0, step}, lag);
        if (dac_b !== 16'h8000) report_mismatch("dac_b(idle)", 32'h8000, 32'(dac_b));
        axi_write(REG_TRIG, 32'h1, lag);
        high_cnt = 0;
        after_cnt = 0;
        for (i = 0; i < 30; i++) begin
            @(posedge adc_clk);
            if (dac_b === to_offset(step)) begin
                if (after_cnt > 0) begin
                    $display("dac_b stepped a second time after one trigger");
                    error_count++;
                end
                high_cnt++;
            end else if (dac_b === 16'h8000) begin
                if (high_cnt > 0) after_cnt++;
            end else begin
                report_mismatch("dac_b", 32'h8000, 32'(dac_b));
            end
        end
        if (high_cnt != 7) report_mismatch("dac_b step length", 32'd7, 32'(high_cnt));
        if (after_cnt == 0) begin
            $display("dac_b did not return to midscale after the step");
            error_count++;
        end
        close_test("step_pulse", start);
    endtask

    task automatic back_pressure();
        int          start;
        int          lag;
        int          i;
        logic [4:0]  addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic [31:0] rd;
        start = error_count;
        stall_en <= 1'b1;
        for (i = 0; i < 24; i++) begin
            lut_seed = lcg_next(lut_seed);
            data = lut_seed;
            case (i % 4)
                0: begin
                    addr = REG_PULSE_LOW;
                    expected = data;
                end
                1: begin
                    addr = REG_PULSE_HIGH;
                    expected = data;
                end
                2: begin
                    addr = REG_PULSE_VAL;
                    expected = {16'h0, data[15:0]};  // upper half reads 0
                end
                default: begin
                    addr = REG_LUT;
                    expected = data;
                end
            endcase
            axi_write(addr, data, lag);
            axi_read(addr, rd);
            if (rd !== expected) report_mismatch("rdata(stalled)", expected, rd);
        end
        stall_en <= 1'b0;
        close_test("back_pressure", start);
    endtask

    // ends a stuck run
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_NS);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        repeat (3) @(posedge adc_clk);
        reset <= 1'b0;
        @(posedge adc_clk);
        register_readback();
        fixed_levels();
        free_run_pattern();
        run_once_pattern();
        step_pulse();
        back_pressure();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
